/* src/elem_cfg_pkg.sv */
////////////////////
// element unit data-path configuration
// widths of the element word and the integer-register index
////////////////////

`default_nettype none

package elem_cfg_pkg;

    // one vector element or scalar operand
    localparam int unsigned WORD_W = 32;

    // index into the integer register file
    localparam int unsigned XREG_ADDR_W = 5;

    typedef logic [WORD_W-1:0] word_t;

    typedef logic [XREG_ADDR_W-1:0] xreg_addr_t;

endpackage

`default_nettype wire

/* src/elem_op_pkg.sv */
////////////////////
// element unit operation and element-width encodings
////////////////////

`default_nettype none

package elem_op_pkg;

    // bit counts of the supported element widths
    localparam int unsigned SEW8_W  = 8;
    localparam int unsigned SEW16_W = 16;
    localparam int unsigned SEW32_W = 32;

    typedef enum logic [3:0] {
        ELEM_XMV,
        ELEM_VID,
        ELEM_VPOPC,
        ELEM_VIOTA,
        ELEM_VFIRST,
        ELEM_VCOMPRESS,
        ELEM_VREDSUM,
        ELEM_VREDAND,
        ELEM_VREDOR,
        ELEM_VREDXOR,
        ELEM_VREDMINU,
        ELEM_VREDMIN,
        ELEM_VREDMAXU,
        ELEM_VREDMAX
    } elem_op_e;

    typedef enum logic [1:0] {
        SEW_8  = 2'd0,
        SEW_16 = 2'd1,
        SEW_32 = 2'd2
    } sew_e;

    // number of significant bits for an element width, unused code acts as 32
    function automatic int unsigned sew_bits(sew_e sew);
        case (sew)
            SEW_8:   return SEW8_W;
            SEW_16:  return SEW16_W;
            default: return SEW32_W;
        endcase
    endfunction

endpackage

`default_nettype wire

/* src/elem_count_unit.sv */
////////////////////
// element counter for vid, vpopc, viota and vfirst
////////////////////

`timescale 1ns/10ps
`default_nettype none

module elem_count_unit import elem_cfg_pkg::*, elem_op_pkg::*; (
    input  wire logic     clk_i,
    input  wire logic     async_rst_ni,
    input  wire logic     accept_i,
    input  wire elem_op_e op_i,
    input  wire logic     first_i,
    input  wire logic     vl_mask_i,
    input  wire logic     masked_i,
    input  wire logic     v0_i,
    input  wire logic     mask_bit_i,
    input  wire word_t    result_q_i,
    output word_t         count_res_o
);

    word_t counter_q;
    word_t counter_d;
    logic  counter_inc;
    logic  v0_eff;
    logic  none_found;

    // an unmasked instruction treats every element as active
    assign v0_eff = v0_i | ~masked_i;

    // vfirst has not yet seen a set bit while the previous result is all ones
    assign none_found = (&result_q_i) & ~mask_bit_i;

    always_comb begin
        counter_inc = 1'b0;
        count_res_o = '0;
        case (op_i)
            ELEM_VID: begin
                counter_inc = 1'b1;
                count_res_o = first_i ? '0 : counter_q;
            end
            ELEM_VPOPC,
            ELEM_VIOTA: begin
                counter_inc = mask_bit_i & vl_mask_i & v0_eff;
                count_res_o = first_i ? '0 : counter_q;
            end
            ELEM_VFIRST: begin
                counter_inc = first_i | none_found;
                if (first_i) begin
                    count_res_o = {WORD_W{~mask_bit_i}};
                end else begin
                    count_res_o = none_found ? '1 : counter_q;
                end
            end
            default: ;
        endcase
    end

    // restart on the first element of each instruction
    assign counter_d = (first_i ? '0 : counter_q) + word_t'(counter_inc);

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (~async_rst_ni) begin
            counter_q <= '0;
        end else if (accept_i) begin
            counter_q <= counter_d;
        end
    end

endmodule

`default_nettype wire

/* src/elem_reduce_alu.sv */
////////////////////
// reduction combiner for sum, logic ops and min/max at 8, 16 or 32 bits
////////////////////

`timescale 1ns/10ps
`default_nettype none

module elem_reduce_alu import elem_cfg_pkg::*, elem_op_pkg::*; (
    input  wire elem_op_e op_i,
    input  wire sew_e     eew_i,
    input  wire logic     first_i,
    input  wire logic     vl_mask_i,
    input  wire word_t    elem_i,
    input  wire word_t    op2_i,
    input  wire word_t    result_q_i,
    output word_t         red_res_o
);

    // widen the low lane by one bit so signed and unsigned share a comparator
    function automatic logic [WORD_W:0] ext_lane(word_t val, int unsigned width, logic sgn);
        logic [WORD_W:0] r;
        for (int i = 0; i < WORD_W; i++) begin
            r[i] = (i < width) ? val[i] : (sgn & val[width-1]);
        end
        r[WORD_W] = sgn & val[width-1];
        return r;
    endfunction

    function automatic word_t lane_bits(int unsigned width);
        word_t m;
        for (int i = 0; i < WORD_W; i++) begin
            m[i] = (i < width);
        end
        return m;
    endfunction

    word_t           acc;
    word_t           lane_mask;
    word_t           minmax_res;
    logic [WORD_W:0] elem_ext;
    logic [WORD_W:0] acc_ext;
    logic            is_signed;
    logic            is_min;
    logic            take_elem;

    // seed on the first element, running value afterwards
    assign acc = first_i ? op2_i : result_q_i;

    ////////////////////
    // min / max
    assign is_signed = (op_i == ELEM_VREDMIN) | (op_i == ELEM_VREDMAX);
    assign is_min    = (op_i == ELEM_VREDMIN) | (op_i == ELEM_VREDMINU);
    assign lane_mask = lane_bits(sew_bits(eew_i));
    assign elem_ext  = ext_lane(elem_i, sew_bits(eew_i), is_signed);
    assign acc_ext   = ext_lane(acc, sew_bits(eew_i), is_signed);
    assign take_elem = is_min ? ($signed(elem_ext) < $signed(acc_ext))
                              : ($signed(acc_ext) < $signed(elem_ext));

    // upper bits above the element width come from the accumulator
    assign minmax_res = (acc & ~lane_mask) | ((take_elem ? elem_i : acc) & lane_mask);

    ////////////////////
    // combine
    always_comb begin
        red_res_o = acc;
        if (vl_mask_i) begin
            case (op_i)
                ELEM_VREDSUM: red_res_o = elem_i + acc;
                ELEM_VREDAND: red_res_o = elem_i & acc;
                ELEM_VREDOR:  red_res_o = elem_i | acc;
                ELEM_VREDXOR: red_res_o = elem_i ^ acc;
                ELEM_VREDMINU,
                ELEM_VREDMIN,
                ELEM_VREDMAXU,
                ELEM_VREDMAX: red_res_o = minmax_res;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/elem_result_mux.sv */
////////////////////
// per-operation result select with result valid and write mask
////////////////////

`timescale 1ns/10ps
`default_nettype none

module elem_result_mux import elem_cfg_pkg::*, elem_op_pkg::*; (
    input  wire elem_op_e op_i,
    input  wire sew_e     eew_i,
    input  wire logic     last_i,
    input  wire logic     vl_mask_i,
    input  wire logic     vl_zero_i,
    input  wire logic     masked_i,
    input  wire logic     v0_i,
    input  wire logic     mask_bit_i,
    input  wire word_t    elem_i,
    input  wire word_t    count_res_i,
    input  wire word_t    red_res_i,
    output word_t         res_d_o,
    output logic          res_valid_d_o,
    output logic          mask_d_o
);

    // replicate the top bit of the element above its width
    function automatic word_t sign_ext(word_t val, int unsigned width);
        word_t r;
        for (int i = 0; i < WORD_W; i++) begin
            r[i] = (i < width) ? val[i] : val[width-1];
        end
        return r;
    endfunction

    logic v0_eff;

    assign v0_eff = v0_i | ~masked_i;

    always_comb begin
        res_d_o       = '0;
        res_valid_d_o = 1'b0;
        mask_d_o      = 1'b0;
        case (op_i)
            // scalar move only feeds the integer write-back
            ELEM_XMV: begin
                res_d_o = sign_ext(elem_i, sew_bits(eew_i));
            end
            ELEM_VID,
            ELEM_VPOPC,
            ELEM_VIOTA,
            ELEM_VFIRST: begin
                res_d_o       = count_res_i;
                res_valid_d_o = 1'b1;
                mask_d_o      = vl_mask_i & v0_eff;
            end
            // only elements with the mask bit set are packed
            ELEM_VCOMPRESS: begin
                res_d_o       = elem_i;
                res_valid_d_o = mask_bit_i;
                mask_d_o      = vl_mask_i;
            end
            default: begin
                res_d_o       = red_res_i;
                res_valid_d_o = last_i;
                mask_d_o      = ~vl_zero_i;
            end
        endcase
    end

endmodule

`default_nettype wire

/* src/elem_result_stage.sv */
////////////////////
// output register with valid/ready handshake and integer write-back
////////////////////

`timescale 1ns/10ps
`default_nettype none

module elem_result_stage import elem_cfg_pkg::*, elem_op_pkg::*; (
    input  wire logic       clk_i,
    input  wire logic       async_rst_ni,
    input  wire logic       in_valid_i,
    input  wire logic       out_ready_i,
    input  wire elem_op_e   op_i,
    input  wire logic       first_i,
    input  wire logic       last_i,
    input  wire logic       xreg_i,
    input  wire xreg_addr_t vd_i,
    input  wire word_t      res_d_i,
    input  wire logic       res_valid_d_i,
    input  wire logic       mask_d_i,
    output logic            in_ready_o,
    output logic            accept_o,
    output word_t           result_q_o,
    output logic            out_valid_o,
    output logic            res_valid_o,
    output word_t           res_o,
    output logic            mask_o,
    output logic            xreg_valid_o,
    output word_t           xreg_data_o,
    output xreg_addr_t      xreg_addr_o
);

    logic       valid_q;
    elem_op_e   op_q;
    logic       first_q;
    logic       last_q;
    logic       xreg_q;
    logic       res_valid_q;
    logic       mask_q;
    word_t      result_q;
    xreg_addr_t vd_q;

    // stage frees up when empty or drained this cycle
    assign in_ready_o = ~valid_q | out_ready_i;
    assign accept_o   = in_valid_i & in_ready_o;

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (~async_rst_ni) begin
            valid_q     <= 1'b0;
            op_q        <= ELEM_XMV;
            first_q     <= 1'b0;
            last_q      <= 1'b0;
            xreg_q      <= 1'b0;
            res_valid_q <= 1'b0;
            mask_q      <= 1'b0;
        end else if (in_ready_o) begin
            valid_q <= in_valid_i;
            if (in_valid_i) begin
                op_q        <= op_i;
                first_q     <= first_i;
                last_q      <= last_i;
                xreg_q      <= xreg_i;
                res_valid_q <= res_valid_d_i;
                mask_q      <= mask_d_i;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept_o) begin
            result_q <= res_d_i;
            vd_q     <= vd_i;
        end
    end

    assign result_q_o  = result_q;
    assign out_valid_o = valid_q;
    assign res_valid_o = res_valid_q;
    assign res_o       = result_q;
    assign mask_o      = mask_q;

    // xmv writes on its first element, everything else once the last is in
    assign xreg_valid_o = xreg_q & ((op_q == ELEM_XMV) ? first_q : last_q);
    assign xreg_data_o  = result_q;
    assign xreg_addr_o  = vd_q;

endmodule

`default_nettype wire

/* src/elem_top.sv */
////////////////////
// element-serial unit of the vector processor
////////////////////

`timescale 1ns/10ps
`default_nettype none

module elem_top import elem_cfg_pkg::*, elem_op_pkg::*; (
    input  wire logic       clk_i,
    input  wire logic       async_rst_ni,
    input  wire logic       in_valid_i,
    output logic            in_ready_o,
    input  wire elem_op_e   op_i,
    input  wire sew_e       eew_i,
    input  wire logic       first_i,
    input  wire logic       last_i,
    input  wire logic       vl_mask_i,
    input  wire logic       vl_zero_i,
    input  wire logic       masked_i,
    input  wire logic       v0_i,
    input  wire word_t      elem_i,
    input  wire word_t      op2_i,
    input  wire logic       xreg_i,
    input  wire xreg_addr_t vd_i,
    output logic            out_valid_o,
    input  wire logic       out_ready_i,
    output logic            res_valid_o,
    output word_t           res_o,
    output logic            mask_o,
    output logic            xreg_valid_o,
    output word_t           xreg_data_o,
    output xreg_addr_t      xreg_addr_o
);

    logic  accept;
    logic  mask_bit;
    word_t result_q;
    word_t count_res;
    word_t red_res;
    word_t res_d;
    logic  res_valid_d;
    logic  mask_d;

    // mask register bit rides in the low bit of the second operand
    assign mask_bit = op2_i[0];

    elem_count_unit count0 (
        .clk_i, .async_rst_ni, .accept_i(accept), .op_i, .first_i, .vl_mask_i,
        .masked_i, .v0_i, .mask_bit_i(mask_bit), .result_q_i(result_q),
        .count_res_o(count_res)
    );

    elem_reduce_alu alu0 (
        .op_i, .eew_i, .first_i, .vl_mask_i, .elem_i, .op2_i,
        .result_q_i(result_q), .red_res_o(red_res)
    );

    elem_result_mux mux0 (
        .op_i, .eew_i, .last_i, .vl_mask_i, .vl_zero_i, .masked_i, .v0_i,
        .mask_bit_i(mask_bit), .elem_i, .count_res_i(count_res), .red_res_i(red_res),
        .res_d_o(res_d), .res_valid_d_o(res_valid_d), .mask_d_o(mask_d)
    );

    elem_result_stage stage0 (
        .clk_i, .async_rst_ni, .in_valid_i, .out_ready_i, .op_i, .first_i, .last_i,
        .xreg_i, .vd_i, .res_d_i(res_d), .res_valid_d_i(res_valid_d), .mask_d_i(mask_d),
        .in_ready_o, .accept_o(accept), .result_q_o(result_q), .out_valid_o,
        .res_valid_o, .res_o, .mask_o, .xreg_valid_o, .xreg_data_o, .xreg_addr_o
    );

endmodule

`default_nettype wire

/* testbench/tb_elem_vectors.svh */
////////////////////
// stimulus and expected outputs for the element unit testbench
////////////////////

`ifndef TB_ELEM_VECTORS_SVH
`define TB_ELEM_VECTORS_SVH

// columns: op, eew, flags, elem, op2, expected res, expected bits
// flags are {first, last, vl_mask, vl_zero, masked, v0, xreg}
// expected bits are {res_valid, mask, xreg_valid}
task automatic load_vectors();
    begin_group("xmv");
    add_row(ELEM_XMV, SEW_8, 7'b1110001, 'hABCD1280, 'h0, 'hFFFFFF80, 3'b001);
    add_row(ELEM_XMV, SEW_16, 7'b1110001, 'h12348000, 'h0, 'hFFFF8000, 3'b001);
    add_row(ELEM_XMV, SEW_32, 7'b1110001, 'h89ABCDEF, 'h0, 'h89ABCDEF, 3'b001);
    add_row(ELEM_XMV, SEW_16, 7'b1110001, 'hFFFF7FFF, 'h0, 'h00007FFF, 3'b001);

    begin_group("vid");
    add_row(ELEM_VID, SEW_32, 7'b1010000, 'h0, 'h0, 'h00000000, 3'b110);
    add_row(ELEM_VID, SEW_32, 7'b0010000, 'h0, 'h0, 'h00000001, 3'b110);
    add_row(ELEM_VID, SEW_32, 7'b0010000, 'h0, 'h0, 'h00000002, 3'b110);
    add_row(ELEM_VID, SEW_32, 7'b0010000, 'h0, 'h0, 'h00000003, 3'b110);
    add_row(ELEM_VID, SEW_32, 7'b0010000, 'h0, 'h0, 'h00000004, 3'b110);
    add_row(ELEM_VID, SEW_32, 7'b0110000, 'h0, 'h0, 'h00000005, 3'b110);

    // v0 masked, last two elements of vpopc lie beyond vl
    begin_group("vpopc/viota");
    add_row(ELEM_VPOPC, SEW_32, 7'b1010110, 'h0, 'h1, 'h00000000, 3'b110);
    add_row(ELEM_VPOPC, SEW_32, 7'b0010100, 'h0, 'h1, 'h00000001, 3'b100);
    add_row(ELEM_VPOPC, SEW_32, 7'b0010110, 'h0, 'h0, 'h00000001, 3'b110);
    add_row(ELEM_VPOPC, SEW_32, 7'b0010110, 'h0, 'h1, 'h00000001, 3'b110);
    add_row(ELEM_VPOPC, SEW_32, 7'b0000110, 'h0, 'h1, 'h00000002, 3'b100);
    add_row(ELEM_VPOPC, SEW_32, 7'b0100110, 'h0, 'h1, 'h00000002, 3'b100);
    add_row(ELEM_VIOTA, SEW_32, 7'b1010110, 'h0, 'h0, 'h00000000, 3'b110);
    add_row(ELEM_VIOTA, SEW_32, 7'b0010110, 'h0, 'h1, 'h00000000, 3'b110);
    add_row(ELEM_VIOTA, SEW_32, 7'b0010100, 'h0, 'h1, 'h00000001, 3'b100);
    add_row(ELEM_VIOTA, SEW_32, 7'b0110110, 'h0, 'h1, 'h00000001, 3'b110);

    // first set bit at index 2, then an instruction with no set bit
    begin_group("vfirst");
    add_row(ELEM_VFIRST, SEW_32, 7'b1010000, 'h0, 'h0, 'hFFFFFFFF, 3'b110);
    add_row(ELEM_VFIRST, SEW_32, 7'b0010000, 'h0, 'h0, 'hFFFFFFFF, 3'b110);
    add_row(ELEM_VFIRST, SEW_32, 7'b0010000, 'h0, 'h1, 'h00000002, 3'b110);
    add_row(ELEM_VFIRST, SEW_32, 7'b0110000, 'h0, 'h0, 'h00000002, 3'b110);
    add_row(ELEM_VFIRST, SEW_32, 7'b1010000, 'h0, 'h0, 'hFFFFFFFF, 3'b110);
    add_row(ELEM_VFIRST, SEW_32, 7'b0010000, 'h0, 'h0, 'hFFFFFFFF, 3'b110);
    add_row(ELEM_VFIRST, SEW_32, 7'b0110000, 'h0, 'h0, 'hFFFFFFFF, 3'b110);

    begin_group("vcompress");
    add_row(ELEM_VCOMPRESS, SEW_32, 7'b1010000, 'hA0000001, 'h1, 'hA0000001, 3'b110);
    add_row(ELEM_VCOMPRESS, SEW_32, 7'b0010000, 'hA0000002, 'h0, 'hA0000002, 3'b010);
    add_row(ELEM_VCOMPRESS, SEW_32, 7'b0010000, 'hA0000003, 'h1, 'hA0000003, 3'b110);
    add_row(ELEM_VCOMPRESS, SEW_32, 7'b0100000, 'hA0000004, 'h1, 'hA0000004, 3'b100);

    // the third element of each lies beyond vl, the last one has vl zero
    begin_group("red logic");
    add_row(ELEM_VREDSUM, SEW_32, 7'b1010001, 'h00000005, 'h00000010, 'h00000015, 3'b010);
    add_row(ELEM_VREDSUM, SEW_32, 7'b0010001, 'hFFFFFFF0, 'h0, 'h00000005, 3'b010);
    add_row(ELEM_VREDSUM, SEW_32, 7'b0100001, 'h12345678, 'h0, 'h00000005, 3'b111);
    add_row(ELEM_VREDAND, SEW_8, 7'b1010001, 'hF0F0FF0F, 'hFFFFFFFF, 'hF0F0FF0F, 3'b010);
    add_row(ELEM_VREDAND, SEW_8, 7'b0010001, 'h3C3C3C3C, 'h0, 'h30303C0C, 3'b010);
    add_row(ELEM_VREDAND, SEW_8, 7'b0100001, 'h00000000, 'h0, 'h30303C0C, 3'b111);
    add_row(ELEM_VREDOR, SEW_16, 7'b1010001, 'h00F00000, 'h00000001, 'h00F00001, 3'b010);
    add_row(ELEM_VREDOR, SEW_16, 7'b0010001, 'h80000100, 'h0, 'h80F00101, 3'b010);
    add_row(ELEM_VREDOR, SEW_16, 7'b0100001, 'hFFFFFFFF, 'h0, 'h80F00101, 3'b111);
    add_row(ELEM_VREDXOR, SEW_32, 7'b1010001, 'hFFFF0000, 'hA5A5A5A5, 'h5A5AA5A5, 3'b010);
    add_row(ELEM_VREDXOR, SEW_32, 7'b0010001, 'h0F0F0F0F, 'h0, 'h5555AAAA, 3'b010);
    add_row(ELEM_VREDXOR, SEW_32, 7'b0100001, 'h33333333, 'h0, 'h5555AAAA, 3'b111);
    add_row(ELEM_VREDSUM, SEW_32, 7'b1101001, 'h11111111, 'h00000042, 'h00000042, 3'b101);

    begin_group("red minmax");
    add_row(ELEM_VREDMINU, SEW_8, 7'b1010001, 'h1111117F, 'hABCDEF80, 'hABCDEF7F, 3'b010);
    add_row(ELEM_VREDMINU, SEW_8, 7'b0110001, 'h00000010, 'h0, 'hABCDEF10, 3'b111);
    add_row(ELEM_VREDMIN, SEW_8, 7'b1010001, 'h00000080, 'hABCDEF10, 'hABCDEF80, 3'b010);
    add_row(ELEM_VREDMIN, SEW_8, 7'b0110001, 'hFFFFFF7F, 'h0, 'hABCDEF80, 3'b111);
    add_row(ELEM_VREDMAXU, SEW_8, 7'b1010001, 'h000000F0, 'h12345610, 'h123456F0, 3'b010);
    add_row(ELEM_VREDMAXU, SEW_8, 7'b0110001, 'hFFFFFF20, 'h0, 'h123456F0, 3'b111);
    add_row(ELEM_VREDMAX, SEW_8, 7'b1010001, 'h00000005, 'h123456F0, 'h12345605, 3'b010);
    add_row(ELEM_VREDMAX, SEW_8, 7'b0110001, 'h00000080, 'h0, 'h12345605, 3'b111);
    add_row(ELEM_VREDMINU, SEW_16, 7'b1010001, 'h00007FFF, 'hDEAD8000, 'hDEAD7FFF, 3'b010);
    add_row(ELEM_VREDMINU, SEW_16, 7'b0110001, 'hFFFF9000, 'h0, 'hDEAD7FFF, 3'b111);
    add_row(ELEM_VREDMIN, SEW_16, 7'b1010001, 'h0000FF00, 'hDEAD0100, 'hDEADFF00, 3'b010);
    add_row(ELEM_VREDMIN, SEW_16, 7'b0110001, 'h00008000, 'h0, 'hDEAD8000, 3'b111);
    add_row(ELEM_VREDMAXU, SEW_16, 7'b1010001, 'h0000FFFF, 'hBEEF0001, 'hBEEFFFFF, 3'b010);
    add_row(ELEM_VREDMAXU, SEW_16, 7'b0110001, 'h00001234, 'h0, 'hBEEFFFFF, 3'b111);
    add_row(ELEM_VREDMAX, SEW_16, 7'b1010001, 'h00008001, 'hBEEFFFFF, 'hBEEFFFFF, 3'b010);
    add_row(ELEM_VREDMAX, SEW_16, 7'b0110001, 'h00000001, 'h0, 'hBEEF0001, 3'b111);
    add_row(ELEM_VREDMINU, SEW_32, 7'b1010001, 'h7FFFFFFF, 'h80000000, 'h7FFFFFFF, 3'b010);
    add_row(ELEM_VREDMINU, SEW_32, 7'b0110001, 'hFFFFFFFF, 'h0, 'h7FFFFFFF, 3'b111);
    add_row(ELEM_VREDMIN, SEW_32, 7'b1010001, 'h80000000, 'h7FFFFFFF, 'h80000000, 3'b010);
    add_row(ELEM_VREDMIN, SEW_32, 7'b0110001, 'h00000000, 'h0, 'h80000000, 3'b111);
    add_row(ELEM_VREDMAXU, SEW_32, 7'b1010001, 'hFFFFFFFE, 'h00000001, 'hFFFFFFFE, 3'b010);
    add_row(ELEM_VREDMAXU, SEW_32, 7'b0110001, 'h7FFFFFFF, 'h0, 'hFFFFFFFE, 3'b111);
    add_row(ELEM_VREDMAX, SEW_32, 7'b1010001, 'h80000000, 'hFFFFFFFF, 'hFFFFFFFF, 3'b010);
    add_row(ELEM_VREDMAX, SEW_32, 7'b0110001, 'h7FFFFFFF, 'h0, 'h7FFFFFFF, 3'b111);
endtask

`endif

/* testbench/tb_elem_top.sv */
////////////////////
// testbench for the element-serial unit
// table driven input side and random back-pressure on the output side
////////////////////

`timescale 1ns/10ps
`default_nettype none

module tb_elem_top import elem_cfg_pkg::*, elem_op_pkg::*; ();

    localparam int          CLK_PERIOD     = 10;
    localparam int          CYCLES_PER_ROW = 40;
    localparam logic [31:0] LFSR_SEED      = 32'h53aab467;

    typedef struct {
        elem_op_e   op;
        sew_e       eew;
        logic [6:0] flags;
        word_t      elem;
        word_t      op2;
        xreg_addr_t vd;
        word_t      expect_res;
        logic [2:0] expect_bits;
        int         grp;
    } vec_row_t;

    vec_row_t rows[$];
    string    group_names[$];
    bit       rows_loaded = 1'b0;
    int       err_count = 0;
    int       accept_count;
    int       out_idx = 0;
    int       group_row_base = 0;
    int       group_err_base = 0;

    logic       clk = 1'b0;
    logic       async_rst_n;
    logic       in_valid;
    logic       in_ready;
    elem_op_e   op;
    sew_e       eew;
    logic       first_el;
    logic       last_el;
    logic       vl_mask;
    logic       vl_zero;
    logic       masked;
    logic       v0;
    word_t      elem;
    word_t      op2;
    logic       xreg;
    xreg_addr_t vd;
    logic       out_valid;
    logic       out_ready;
    logic       res_valid;
    word_t      res;
    logic       mask;
    logic       xreg_valid;
    word_t      xreg_data;
    xreg_addr_t xreg_addr;

    always #(CLK_PERIOD / 2) clk = ~clk;

    elem_top dut0 (
        .clk_i(clk), .async_rst_ni(async_rst_n), .in_valid_i(in_valid),
        .in_ready_o(in_ready), .op_i(op), .eew_i(eew), .first_i(first_el),
        .last_i(last_el), .vl_mask_i(vl_mask), .vl_zero_i(vl_zero), .masked_i(masked),
        .v0_i(v0), .elem_i(elem), .op2_i(op2), .xreg_i(xreg), .vd_i(vd),
        .out_valid_o(out_valid), .out_ready_i(out_ready), .res_valid_o(res_valid),
        .res_o(res), .mask_o(mask), .xreg_valid_o(xreg_valid), .xreg_data_o(xreg_data),
        .xreg_addr_o(xreg_addr)
    );

    // count input handshakes so the driver knows when a row was taken
    always @(posedge clk or negedge async_rst_n) begin
        if (!async_rst_n) begin
            accept_count <= 0;
        end else if (in_valid && in_ready) begin
            accept_count <= accept_count + 1;
        end
    end

    ////////////////////
    // helpers
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        // taps 32, 22, 2, 1
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic check_value(input int row, input string what, input word_t got,
                               input word_t expected);
        if (got !== expected) begin
            $display("error @ %0t ns: row %0d %s is %h, expected %h",
                     $time, row, what, got, expected);
            err_count++;
        end
    endtask

    task automatic begin_group(input string name);
        group_names.push_back(name);
    endtask

    task automatic add_row(input elem_op_e op_v, input sew_e eew_v, input logic [6:0] flags_v,
                           input word_t elem_v, input word_t op2_v, input word_t res_v,
                           input logic [2:0] bits_v);
        vec_row_t r;
        r.op          = op_v;
        r.eew         = eew_v;
        r.flags       = flags_v;
        r.elem        = elem_v;
        r.op2         = op2_v;
        r.vd          = xreg_addr_t'(rows.size());
        r.expect_res  = res_v;
        r.expect_bits = bits_v;
        r.grp         = group_names.size() - 1;
        rows.push_back(r);
    endtask

    `include "tb_elem_vectors.svh"

    task automatic apply_row(input vec_row_t r);
        op   = r.op;
        eew  = r.eew;
        {first_el, last_el, vl_mask, vl_zero, masked, v0, xreg} = r.flags;
        elem = r.elem;
        op2  = r.op2;
        vd   = r.vd;
    endtask

    task automatic compare_output();
        vec_row_t r;
        r = rows[out_idx];
        check_value(out_idx, "res_valid", word_t'(res_valid), word_t'(r.expect_bits[2]));
        check_value(out_idx, "res", res, r.expect_res);
        check_value(out_idx, "mask", word_t'(mask), word_t'(r.expect_bits[1]));
        check_value(out_idx, "xreg_valid", word_t'(xreg_valid), word_t'(r.expect_bits[0]));
        if (r.expect_bits[0]) begin
            check_value(out_idx, "xreg_data", xreg_data, r.expect_res);
            check_value(out_idx, "xreg_addr", word_t'(xreg_addr), word_t'(r.vd));
        end
        // a group ends at the last row or where the next row starts another
        if (out_idx == rows.size() - 1 || rows[out_idx + 1].grp != r.grp) begin
            $display("test %-12s %0d rows, %0d errors", group_names[r.grp],
                     out_idx + 1 - group_row_base, err_count - group_err_base);
            group_row_base = out_idx + 1;
            group_err_base = err_count;
        end
        out_idx++;
    endtask

    ////////////////////
    // input side
    initial begin : drive_inputs
        async_rst_n = 1'b0;
        in_valid    = 1'b0;
        out_ready   = 1'b0;
        op          = ELEM_XMV;
        eew         = SEW_8;
        first_el    = 1'b0;
        last_el     = 1'b0;
        vl_mask     = 1'b0;
        vl_zero     = 1'b0;
        masked      = 1'b0;
        v0          = 1'b0;
        elem        = '0;
        op2         = '0;
        xreg        = 1'b0;
        vd          = '0;
        load_vectors();
        rows_loaded = 1'b1;

        repeat (2) @(posedge clk);
        @(negedge clk);
        async_rst_n = 1'b1;
        check_value(-1, "out_valid after reset", word_t'(out_valid), '0);
        check_value(-1, "xreg_valid after reset", word_t'(xreg_valid), '0);

        // hold each row until the DUT takes it
        for (int i = 0; i < rows.size(); i++) begin
            apply_row(rows[i]);
            in_valid = 1'b1;
            @(negedge clk);
            while (accept_count <= i) begin
                @(negedge clk);
            end
        end
        in_valid = 1'b0;

        wait (out_idx == rows.size());
        repeat (4) @(negedge clk);
        $display("summary: %0d of %0d rows checked, %0d errors",
                 out_idx, rows.size(), err_count);
        if (err_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    ////////////////////
    // output side
    initial begin : drain_outputs
        logic [31:0] lfsr;
        logic        held;
        word_t       held_res;
        word_t       held_xdata;
        word_t       held_flags;
        lfsr = LFSR_SEED;
        held = 1'b0;
        wait (async_rst_n === 1'b1);
        forever begin
            @(negedge clk);
            // the stage holds one element from its accept edge until drained
            check_value(out_idx, "out_valid", word_t'(out_valid),
                        word_t'(accept_count != out_idx));
            check_value(out_idx, "in_ready", word_t'(in_ready),
                        word_t'(accept_count == out_idx || out_ready));
            // a stalled result must not move
            if (held) begin
                check_value(out_idx, "res while stalled", res, held_res);
                check_value(out_idx, "xreg_data while stalled", xreg_data, held_xdata);
                check_value(out_idx, "flags while stalled",
                            word_t'({out_valid, res_valid, mask, xreg_valid, xreg_addr}),
                            held_flags);
            end
            lfsr      = lfsr_step(lfsr);
            out_ready = lfsr[0];
            held      = out_valid && !out_ready;
            if (held) begin
                held_res   = res;
                held_xdata = xreg_data;
                held_flags = word_t'({out_valid, res_valid, mask, xreg_valid, xreg_addr});
            end
            if (out_valid && out_ready) begin
                if (out_idx < rows.size()) begin
                    compare_output();
                end else begin
                    $display("the DUT sent an output after the last expected row at %0t ns",
                             $time);
                    err_count++;
                end
            end
        end
    end

    initial begin : watchdog
        wait (rows_loaded);
        #(rows.size() * CYCLES_PER_ROW * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d cycles, %0d of %0d rows seen",
                 rows.size() * CYCLES_PER_ROW, out_idx, rows.size());
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
+incdir+testbench
src/elem_cfg_pkg.sv
src/elem_op_pkg.sv
src/elem_count_unit.sv
src/elem_reduce_alu.sv
src/elem_result_mux.sv
src/elem_result_stage.sv
src/elem_top.sv
testbench/tb_elem_top.sv

/* run.sh */
#!/bin/sh
# build and run the element unit regression with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f build.f --top-module tb_elem_top -o tb_elem_top

# the log is the record of the run, the pass line decides the status
./obj_dir/tb_elem_top | tee sim.log

grep -q "Regression passed" sim.log
echo "simulation log in sim.log"
